//--- icache_top.f
design/icache_geom_pkg.sv
design/refill_bus_pkg.sv
design/icache_tag_ram.sv
design/icache_data_ram.sv
design/icache_age_lru.sv
design/icache_ctrl.sv
design/icache_top.sv
tests/icache_props.sv
tests/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the icache testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f icache_top.f

# the error limit keeps the run going so that every failure is counted
./obj_dir/Vicache_tb +verilator+error+limit+1000 | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi

//--- tests/icache_tb.sv
//######################################################################
// icache testbench
// Drives fetches into the instruction cache with a behavioral refill
// memory and random stalls. Counts refill requests against a model
// of the replacement rules and reports the error totals.
//######################################################################
module icache_tb
    import icache_geom_pkg::*;
    import refill_bus_pkg::*;
();

    localparam int N_RANDOM    = 40;
    localparam int N_FETCH     = 6 + N_RANDOM;
    localparam int CYCLE_LIMIT = 16 + N_FETCH * 20 + 200;  // 20 covers the worst stalls.

    localparam logic [ADDR_W-1:0] ADDR_A = 64'h0000_0000_0000_0128;
    localparam logic [ADDR_W-1:0] ADDR_B = 64'h0000_00a0_0000_012c;
    localparam logic [ADDR_W-1:0] ADDR_C = 64'h7f00_0000_0000_0128;

    logic              clk = 1'b0;
    logic              i_rst_n;
    logic              i_fetch_valid;
    logic [ADDR_W-1:0] i_fetch_addr;
    logic              o_fetch_ready;
    logic              o_inst_valid;
    logic [INST_W-1:0] o_inst_data;
    logic              i_inst_ready;
    logic              o_mem_req_valid;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              i_mem_req_ready;
    logic              i_mem_resp_valid;
    line_word_u        i_mem_resp_data;

    int                seed = 32'h72ce_cc7b;
    int                error_count = 0;
    int                mem_req_count = 0;
    int                expected_misses = 0;
    int                cycle_count = 0;
    int                stall_run = 0;
    logic [31:0]       rnd;
    logic [31:0]       mem_rnd;
    logic [31:0]       stall_rnd;
    logic [ADDR_W-1:0] line_addr;
    logic [ADDR_W-1:0] pool [8];

    // reference state of the two ways, per set.
    logic [TAG_W-1:0]  model_tag   [NUM_SETS][2];
    logic              model_valid [NUM_SETS][2];
    logic [AGE_W-1:0]  model_age   [NUM_SETS][2];

    icache_top uut (.*);

    always #10 clk = ~clk;

    function automatic logic [LINE_W-1:0] line_pattern(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-OFFSET_W-1:0] line;
        line = addr[ADDR_W-1:OFFSET_W];
        return ({{OFFSET_W{1'b0}}, line} * 64'h9e37_79b9_7f4a_7c15) ^ {line[31:0], line[60:29]};
    endfunction

    // ages every entry, then looks up and fills like the cache should.
    task automatic predict_fetch(input logic [ADDR_W-1:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 way;
        logic               found;
        idx   = addr[OFFSET_W +: INDEX_W];
        tag   = addr[ADDR_W-1 -: TAG_W];
        way   = 0;
        found = 1'b0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (model_age[s][w] != AGE_MAX) begin
                    model_age[s][w] = model_age[s][w] + 1'b1;
                end
            end
        end
        for (int w = 0; w < 2; w++) begin
            if (!found && model_valid[idx][w] && model_tag[idx][w] == tag) begin
                found = 1'b1;
                way   = w;
            end
        end
        if (!found) begin
            expected_misses++;
            if (!model_valid[idx][0]) begin
                way = 0;
            end else if (!model_valid[idx][1]) begin
                way = 1;
            end else begin
                way = (model_age[idx][1] > model_age[idx][0]) ? 1 : 0;
            end
            model_valid[idx][way] = 1'b1;
            model_tag[idx][way]   = tag;
        end
        model_age[idx][way] = '0;
    endtask

    task automatic run_fetch(input logic [ADDR_W-1:0] addr);
        predict_fetch(addr);
        i_fetch_valid <= 1'b1;
        i_fetch_addr  <= addr;
        @(posedge clk);
        while (!o_fetch_ready) begin
            @(posedge clk);
        end
        i_fetch_valid <= 1'b0;
        @(posedge clk);
        while (!(o_inst_valid && i_inst_ready)) begin
            @(posedge clk);
        end
    endtask

    // refill memory, random ready and response delays of 0 to 3 cycles.
    initial begin : memory_model
        forever begin
            @(posedge clk);
            if (i_rst_n && o_mem_req_valid) begin
                mem_rnd = $random(seed);
                repeat (mem_rnd[1:0]) @(posedge clk);
                i_mem_req_ready <= 1'b1;
                @(posedge clk);
                mem_req_count++;  // request taken at this edge.
                line_addr = o_mem_addr;
                i_mem_req_ready <= 1'b0;
                repeat (mem_rnd[3:2]) @(posedge clk);
                i_mem_resp_valid      <= 1'b1;
                i_mem_resp_data.dword <= line_pattern(line_addr);
                @(posedge clk);
                i_mem_resp_valid <= 1'b0;
            end
        end
    end

    // core side stalls, never more than 3 cycles in a row.
    always @(posedge clk) begin
        stall_rnd = $random(seed);
        if (stall_run == 3 || stall_rnd[1:0] != 2'd0) begin
            i_inst_ready <= 1'b1;
            stall_run    <= 0;
        end else begin
            i_inst_ready <= 1'b0;
            stall_run    <= stall_run + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the fetch sequence did not complete", CYCLE_LIMIT);
            $display("assertion failures: %0d, testbench errors: %0d",
                     uut.u_props.fail_count, error_count + 1);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        i_rst_n          = 1'b0;
        i_fetch_valid    = 1'b0;
        i_fetch_addr     = '0;
        i_inst_ready     = 1'b0;
        i_mem_req_ready  = 1'b0;
        i_mem_resp_valid = 1'b0;
        i_mem_resp_data  = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                model_tag[s][w]   = '0;
                model_valid[s][w] = 1'b0;
                model_age[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);

        // A, B and C share one set, C must evict B.
        run_fetch(ADDR_A);
        run_fetch(ADDR_B);
        run_fetch(ADDR_A);
        run_fetch(ADDR_C);
        run_fetch(ADDR_A);
        run_fetch(ADDR_B);
        if (mem_req_count != 4) begin
            $display("CHECK FAILED t=%0t mem_req_count got %0d expected %0d",
                     $time, mem_req_count, 4);
            error_count++;
        end

        // pool over three sets, so that ways get evicted.
        for (int k = 0; k < 7; k++) begin
            pool[k][63:32] = $random(seed);
            pool[k][31:0]  = $random(seed);
            pool[k][OFFSET_W +: INDEX_W] = INDEX_W'(k % 3);
        end
        pool[7] = pool[0] ^ 64'h4;  // other half of the same doubleword.

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            run_fetch(pool[rnd[2:0]]);
        end
        if (mem_req_count != expected_misses) begin
            $display("CHECK FAILED t=%0t mem_req_count got %0d expected %0d",
                     $time, mem_req_count, expected_misses);
            error_count++;
        end

        repeat (4) @(posedge clk);
        $display("assertion failures: %0d, testbench errors: %0d",
                 uut.u_props.fail_count, error_count);
        if (uut.u_props.fail_count == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/icache_props.sv
//######################################################################
// icache protocol and data properties
// Concurrent checks on the fetch, response and refill ports of the
// instruction cache. Bound into the cache top level.
//######################################################################
module icache_props
    import icache_geom_pkg::*;
    import refill_bus_pkg::*;
(
    input logic              clk,
    input logic              i_rst_n,
    input logic              i_fetch_valid,
    input logic [ADDR_W-1:0] i_fetch_addr,
    input logic              i_fetch_ready,
    input logic              i_inst_valid,
    input logic [INST_W-1:0] i_inst_data,
    input logic              i_inst_ready,
    input logic              i_mem_req_valid,
    input logic [ADDR_W-1:0] i_mem_addr,
    input logic              i_mem_req_ready
);

    int fail_count = 0;

    logic              accept;
    logic [ADDR_W-1:0] last_addr;    // most recently accepted fetch.
    logic [ADDR_W-1:0] req_expect;
    logic              have_last;
    logic              hit_expected; // same doubleword as the fetch before.
    logic              busy;

    // memory contents as a function of the line address.
    function automatic logic [LINE_W-1:0] line_pattern(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-OFFSET_W-1:0] line;
        line = addr[ADDR_W-1:OFFSET_W];
        return ({{OFFSET_W{1'b0}}, line} * 64'h9e37_79b9_7f4a_7c15) ^ {line[31:0], line[60:29]};
    endfunction

    function automatic logic [INST_W-1:0] expect_inst(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line_word;
        line_word = line_pattern(addr);
        return addr[OFFSET_W-1] ? line_word[LINE_W-1:INST_W] : line_word[INST_W-1:0];
    endfunction

    assign accept     = i_fetch_valid && i_fetch_ready;
    assign req_expect = {last_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_addr    <= '0;
            have_last    <= 1'b0;
            hit_expected <= 1'b0;
            busy         <= 1'b0;
        end else if (accept) begin
            last_addr    <= i_fetch_addr;
            have_last    <= 1'b1;
            hit_expected <= have_last &&
                (i_fetch_addr[ADDR_W-1:OFFSET_W] == last_addr[ADDR_W-1:OFFSET_W]);
            busy         <= 1'b1;
        end else if (i_inst_valid && i_inst_ready) begin
            busy <= 1'b0;
        end
    end

    a_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_inst_valid |-> (i_inst_data == expect_inst(last_addr)))
    else begin
        $error("CHECK FAILED t=%0t o_inst_data got %h expected %h", $time,
               $sampled(i_inst_data), expect_inst($sampled(last_addr)));
        fail_count++;
    end

    a_req_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_req_valid |-> (i_mem_addr == req_expect))
    else begin
        $error("CHECK FAILED t=%0t o_mem_addr got %h expected %h", $time,
               $sampled(i_mem_addr), $sampled(req_expect));
        fail_count++;
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_mem_req_valid && !i_mem_req_ready |=> i_mem_req_valid && $stable(i_mem_addr))
    else begin
        $error("refill request changed or dropped before it was accepted");
        fail_count++;
    end

    a_req_timing: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(i_mem_req_valid) |-> $past(accept, 3))
    else begin
        $error("refill request did not rise two cycles after the fetch was accepted");
        fail_count++;
    end

    a_hit_no_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        hit_expected |-> !i_mem_req_valid)
    else begin
        $error("refill request issued for a doubleword that should hit");
        fail_count++;
    end

    a_hit_timing: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(i_inst_valid) && hit_expected |-> $past(accept, 3))
    else begin
        $error("hit response did not rise two cycles after the fetch was accepted");
        fail_count++;
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_inst_valid && !i_inst_ready |=> i_inst_valid && $stable(i_inst_data))
    else begin
        $error("instruction response changed while the core stalled it");
        fail_count++;
    end

    a_busy_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        busy |-> !i_fetch_ready)
    else begin
        $error("fetch ready was high while a fetch was still in flight");
        fail_count++;
    end

    a_ready_after: assert property (@(posedge clk) disable iff (!i_rst_n)
        $fell(busy) |-> i_fetch_ready)
    else begin
        $error("fetch ready stayed low after the response was taken");
        fail_count++;
    end

    a_reset: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !i_inst_valid && !i_mem_req_valid && i_fetch_ready)
    else begin
        $error("outputs not in their idle values right after reset");
        fail_count++;
    end

endmodule

bind icache_top icache_props u_props (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_fetch_valid   (i_fetch_valid),
    .i_fetch_addr    (i_fetch_addr),
    .i_fetch_ready   (o_fetch_ready),
    .i_inst_valid    (o_inst_valid),
    .i_inst_data     (o_inst_data),
    .i_inst_ready    (i_inst_ready),
    .i_mem_req_valid (o_mem_req_valid),
    .i_mem_addr      (o_mem_addr),
    .i_mem_req_ready (i_mem_req_ready)
);

//--- design/icache_top.sv
//######################################################################
// icache top level
// Two-way instruction cache: controller, per-way tag and data
// arrays and the age-based replacement tracker.
//######################################################################
module icache_top
    import icache_geom_pkg::*;
    import refill_bus_pkg::*;
(
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_fetch_valid,
    input  logic [ADDR_W-1:0] i_fetch_addr,
    output logic              o_fetch_ready,
    output logic              o_inst_valid,
    output logic [INST_W-1:0] o_inst_data,
    input  logic              i_inst_ready,
    output logic              o_mem_req_valid,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_req_ready,
    input  logic              i_mem_resp_valid,
    input  line_word_u        i_mem_resp_data
);

    logic [INDEX_W-1:0] ram_index;
    logic [TAG_W-1:0]   wr_tag;
    line_word_u         wr_data;
    logic               we0;
    logic               we1;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    line_word_u         data0;
    line_word_u         data1;
    logic               tick;
    logic               touch;
    logic               touch_way;
    logic               victim_way;

    icache_ctrl u_ctrl (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_fetch_valid    (i_fetch_valid),
        .i_fetch_addr     (i_fetch_addr),
        .o_fetch_ready    (o_fetch_ready),
        .o_inst_valid     (o_inst_valid),
        .o_inst_data      (o_inst_data),
        .i_inst_ready     (i_inst_ready),
        .o_mem_req_valid  (o_mem_req_valid),
        .o_mem_addr       (o_mem_addr),
        .i_mem_req_ready  (i_mem_req_ready),
        .i_mem_resp_valid (i_mem_resp_valid),
        .i_mem_resp_data  (i_mem_resp_data),
        .o_ram_index      (ram_index),
        .o_wr_tag         (wr_tag),
        .o_wr_data        (wr_data),
        .o_we0            (we0),
        .o_we1            (we1),
        .i_tag0           (tag0),
        .i_tag1           (tag1),
        .i_valid0         (valid0),
        .i_valid1         (valid1),
        .i_data0          (data0),
        .i_data1          (data1),
        .o_tick           (tick),
        .o_touch          (touch),
        .o_touch_way      (touch_way),
        .i_victim_way     (victim_way)
    );

    icache_tag_ram u_tag0 (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (ram_index),
        .i_we    (we0),
        .i_tag   (wr_tag),
        .o_tag   (tag0),
        .o_valid (valid0)
    );

    icache_tag_ram u_tag1 (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_index (ram_index),
        .i_we    (we1),
        .i_tag   (wr_tag),
        .o_tag   (tag1),
        .o_valid (valid1)
    );

    icache_data_ram u_data0 (
        .clk     (clk),
        .i_index (ram_index),
        .i_we    (we0),
        .i_data  (wr_data),
        .o_data  (data0)
    );

    icache_data_ram u_data1 (
        .clk     (clk),
        .i_index (ram_index),
        .i_we    (we1),
        .i_data  (wr_data),
        .o_data  (data1)
    );

    icache_age_lru u_age (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_tick       (tick),
        .i_touch      (touch),
        .i_touch_way  (touch_way),
        .i_index      (ram_index),
        .i_valid0     (valid0),
        .i_valid1     (valid1),
        .o_victim_way (victim_way)
    );

endmodule

//--- design/icache_ctrl.sv
//######################################################################
// icache controller
// Blocking lookup and refill FSM. Holds the accepted fetch address,
// compares both ways, selects the instruction half and fills the
// victim way from a single-beat memory response.
//######################################################################
module icache_ctrl
    import icache_geom_pkg::*;
    import refill_bus_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst_n,
    // core fetch port.
    input  logic               i_fetch_valid,
    input  logic [ADDR_W-1:0]  i_fetch_addr,
    output logic               o_fetch_ready,
    output logic               o_inst_valid,
    output logic [INST_W-1:0]  o_inst_data,
    input  logic               i_inst_ready,
    // memory refill port.
    output logic               o_mem_req_valid,
    output logic [ADDR_W-1:0]  o_mem_addr,
    input  logic               i_mem_req_ready,
    input  logic               i_mem_resp_valid,
    input  line_word_u         i_mem_resp_data,
    // tag and data arrays.
    output logic [INDEX_W-1:0] o_ram_index,
    output logic [TAG_W-1:0]   o_wr_tag,
    output line_word_u         o_wr_data,
    output logic               o_we0,
    output logic               o_we1,
    input  logic [TAG_W-1:0]   i_tag0,
    input  logic [TAG_W-1:0]   i_tag1,
    input  logic               i_valid0,
    input  logic               i_valid1,
    input  line_word_u         i_data0,
    input  line_word_u         i_data1,
    // age tracker.
    output logic               o_tick,
    output logic               o_touch,
    output logic               o_touch_way,
    input  logic               i_victim_way
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_LOOKUP = 3'd1;
    localparam logic [2:0] S_RESP   = 3'd2;
    localparam logic [2:0] S_REQ    = 3'd3;
    localparam logic [2:0] S_WAIT   = 3'd4;

    logic [2:0]        state;
    logic [ADDR_W-1:0] addr_q;
    logic              rd_done;   // arrays have returned the set.
    logic              victim_q;
    logic [INST_W-1:0] inst_q;

    logic              fetch_fire;
    logic              hit0;
    logic              hit1;
    logic              lookup_hit;
    logic              lookup_miss;
    logic              fill;
    logic              inst_sel;
    line_word_u        hit_line;

    assign fetch_fire  = i_fetch_valid && (state == S_IDLE);
    assign inst_sel    = addr_q[OFFSET_W-1];  // bit 2 picks the word.

    assign hit0        = i_valid0 && (i_tag0 == addr_q[ADDR_W-1 -: TAG_W]);
    assign hit1        = i_valid1 && (i_tag1 == addr_q[ADDR_W-1 -: TAG_W]);
    assign lookup_hit  = (state == S_LOOKUP) && rd_done && (hit0 || hit1);
    assign lookup_miss = (state == S_LOOKUP) && rd_done && !(hit0 || hit1);
    assign hit_line    = hit1 ? i_data1 : i_data0;
    assign fill        = (state == S_WAIT) && i_mem_resp_valid;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= S_IDLE;
            rd_done  <= 1'b0;
            victim_q <= 1'b0;
        end else begin
            rd_done <= (state == S_LOOKUP) && !rd_done;
            case (state)
                S_IDLE: begin
                    if (fetch_fire) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (lookup_hit) begin
                        state <= S_RESP;
                    end else if (lookup_miss) begin
                        state    <= S_REQ;
                        victim_q <= i_victim_way;
                    end
                end
                S_REQ: begin
                    if (i_mem_req_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (i_mem_resp_valid) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (i_inst_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            addr_q <= i_fetch_addr;
        end
        if (lookup_hit) begin
            inst_q <= hit_line.inst[inst_sel];
        end else if (fill) begin
            inst_q <= i_mem_resp_data.inst[inst_sel];  // forward the refill word.
        end
    end

    assign o_fetch_ready   = (state == S_IDLE);
    assign o_inst_valid    = (state == S_RESP);
    assign o_inst_data     = inst_q;
    assign o_mem_req_valid = (state == S_REQ);
    assign o_mem_addr      = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign o_ram_index = addr_q[OFFSET_W +: INDEX_W];
    assign o_wr_tag    = addr_q[ADDR_W-1 -: TAG_W];
    assign o_wr_data   = i_mem_resp_data;
    assign o_we0       = fill && !victim_q;
    assign o_we1       = fill && victim_q;

    assign o_tick      = fetch_fire;
    assign o_touch     = lookup_hit || fill;
    assign o_touch_way = fill ? victim_q : hit1;

endmodule

//--- design/icache_age_lru.sv
//######################################################################
// icache age tracker
// Saturating age per set and way. Every accepted fetch ages all
// entries, a hit or fill clears the touched way. The victim is an
// invalid way first, then the older one.
//######################################################################
module icache_age_lru
    import icache_geom_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_tick,
    input  logic               i_touch,
    input  logic               i_touch_way,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_valid0,
    input  logic               i_valid1,
    output logic               o_victim_way
);

    logic [AGE_W-1:0] age0 [NUM_SETS];
    logic [AGE_W-1:0] age1 [NUM_SETS];

    function automatic logic [AGE_W-1:0] age_inc(input logic [AGE_W-1:0] age);
        return (age == AGE_MAX) ? AGE_MAX : age + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SETS; s++) begin
                if (i_touch && (s == i_index) && !i_touch_way) begin
                    age0[s] <= '0;  // touch wins over the tick.
                end else if (i_tick) begin
                    age0[s] <= age_inc(age0[s]);
                end
                if (i_touch && (s == i_index) && i_touch_way) begin
                    age1[s] <= '0;
                end else if (i_tick) begin
                    age1[s] <= age_inc(age1[s]);
                end
            end
        end
    end

    always_comb begin
        if (!i_valid0) begin
            o_victim_way = 1'b0;
        end else if (!i_valid1) begin
            o_victim_way = 1'b1;
        end else begin
            o_victim_way = (age1[i_index] > age0[i_index]);  // tie goes to way 0.
        end
    end

endmodule

//--- design/icache_data_ram.sv
//######################################################################
// icache data store
// One way of instruction data, a doubleword per set, with a
// synchronous read and write.
//######################################################################
module icache_data_ram
    import icache_geom_pkg::*;
    import refill_bus_pkg::*;
(
    input  logic               clk,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_we,
    input  line_word_u         i_data,
    output line_word_u         o_data
);

    line_word_u data_mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            data_mem[i_index] <= i_data;
        end
    end

    // old contents come out on a same-cycle write.
    always_ff @(posedge clk) begin
        o_data <= data_mem[i_index];
    end

endmodule

//--- design/icache_tag_ram.sv
//######################################################################
// icache tag store
// One way of tags with a valid bit per set. Read and write are
// synchronous, valid bits clear on reset.
//######################################################################
module icache_tag_ram
    import icache_geom_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_we,
    input  logic [TAG_W-1:0]   i_tag,
    output logic [TAG_W-1:0]   o_tag,
    output logic               o_valid
);

    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_tag;
        end
        o_tag <= tag_mem[i_index];  // registered read.
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_we) begin
                valid_q[i_index] <= 1'b1;
            end
            o_valid <= valid_q[i_index];
        end
    end

endmodule

//--- design/refill_bus_pkg.sv
//######################################################################
// refill bus definitions
// Memory-side word width and the two views of a fetched doubleword:
// the whole line as stored, or its pair of instructions.
//######################################################################
package refill_bus_pkg;

    localparam int LINE_W = 64;

    // inst[1] is the upper half, picked when address bit 2 is set.
    typedef union packed {
        logic [LINE_W-1:0]             dword;
        logic [1:0][(LINE_W/2)-1:0]    inst;
    } line_word_u;

endpackage

//--- design/icache_geom_pkg.sv
//######################################################################
// icache geometry
// Address field widths, set count and age counter sizing for the
// two-way instruction cache with one doubleword per line.
//######################################################################
package icache_geom_pkg;

    // fetch address fields.
    localparam int ADDR_W   = 64;
    localparam int OFFSET_W = 3;  // byte offset in a doubleword.
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // array sizes.
    localparam int NUM_SETS = 1 << INDEX_W;

    // replacement age counters.
    localparam int AGE_W = 3;
    localparam logic [AGE_W-1:0] AGE_MAX = 3'd7;  // saturation point.

    // one instruction out of a doubleword.
    localparam int INST_W = 32;

endpackage
